//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_core
FLIST      := flist.f
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing
LOG        := sim.log
PASS_MSG   := Done: no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf obj_dir $(LOG)

//--- flist.f
+incdir+logic
logic/rv_pkg.sv
logic/rv_datapath.sv
logic/rv_controller.sv
logic/rv_hazard.sv
logic/rv_exception.sv
logic/rv_core.sv
sim/tb_clock.sv
sim/core_sva.sv
sim/tb_core.sv

//--- logic/rv_consts.svh
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// data and address width
`define RV_XLEN 32

// integer register count, x0 included
`define RV_NREGS 32

// first fetch after reset
`define RV_RESET_VEC 32'h0000_0000

// fetch target for every trap
`define RV_TRAP_VEC 32'h0000_0100

`endif

//--- logic/rv_controller.sv
`timescale 1ns/1ns

module rv_controller import rv_pkg::*; (
  input  logic        clk,
  input  logic        i_rst_n,
  input  logic [31:0] i_inst_d,
  input  hazard_t     i_hazard,
  input  logic        i_fault,
  output ex_ctrl_t    o_ex_ctrl,
  output mem_ctrl_t   o_mem_ctrl,
  output mem_ctrl_t   o_mem_ctrl_e,
  output wb_ctrl_t    o_wb_ctrl,
  output logic        o_load_e,
  output logic        o_regwrite_m,
  output logic        o_regwrite_w
);

  logic [2:0] f3;
  logic [6:0] f7;
  logic       f7_zero, f7_alt;
  ex_ctrl_t   ex_d, ex_e;
  mem_ctrl_t  mem_d, mem_e, mem_m;
  wb_ctrl_t   wb_d, wb_e, wb_m, wb_w;

  function automatic alu_op_e alu_from_f3(input logic [2:0] f, input logic alt);
    case (f)
      3'b000:  alu_from_f3 = alt ? ALU_SUB : ALU_ADD;
      3'b001:  alu_from_f3 = ALU_SLL;
      3'b010:  alu_from_f3 = ALU_SLT;
      3'b011:  alu_from_f3 = ALU_SLTU;
      3'b100:  alu_from_f3 = ALU_XOR;
      3'b101:  alu_from_f3 = alt ? ALU_SRA : ALU_SRL;
      3'b110:  alu_from_f3 = ALU_OR;
      default: alu_from_f3 = ALU_AND;
    endcase
  endfunction

  assign f3      = i_inst_d[14:12];
  assign f7      = i_inst_d[31:25];
  assign f7_zero = (f7 == 7'b0000000);
  assign f7_alt  = (f7 == 7'b0100000);

  always_comb begin
    ex_d  = '0;
    mem_d = '0;
    wb_d  = '0;
    case (opcode_e'(i_inst_d[6:0]))
      OPC_OP: begin
        ex_d.alu_op  = alu_from_f3(f3, f7_alt);
        ex_d.illegal = !(f7_zero || (f7_alt && (f3 == 3'b000 || f3 == 3'b101)));
        wb_d.reg_write = 1'b1;
      end
      OPC_OP_IMM: begin
        // only shifts carry funct7
        ex_d.alu_op  = alu_from_f3(f3, f3 == 3'b101 && f7_alt);
        ex_d.alu_src = 1'b1;
        ex_d.illegal = (f3 == 3'b001 && !f7_zero) ||
                       (f3 == 3'b101 && !(f7_zero || f7_alt));
        wb_d.reg_write = 1'b1;
      end
      OPC_LUI: begin
        ex_d.alu_op    = ALU_PASS_B;
        ex_d.alu_src   = 1'b1;
        wb_d.reg_write = 1'b1;
      end
      OPC_LOAD: begin
        ex_d.alu_src      = 1'b1;
        ex_d.illegal      = (f3[1:0] == 2'b11) || (f3[2] && f3[1]);
        mem_d.req         = 1'b1;
        mem_d.size        = mem_size_e'(f3[1:0]);
        mem_d.load_signed = !f3[2];
        wb_d.reg_write    = 1'b1;
        wb_d.mem_to_reg   = 1'b1;
      end
      OPC_STORE: begin
        ex_d.alu_src = 1'b1;
        ex_d.illegal = f3[2] || (f3[1:0] == 2'b11);
        mem_d.req    = 1'b1;
        mem_d.write  = 1'b1;
        mem_d.size   = mem_size_e'(f3[1:0]);
      end
      OPC_BRANCH: begin
        ex_d.branch  = 1'b1;
        ex_d.br_cond = f3;
        ex_d.illegal = f3[1];
      end
      OPC_JAL: begin
        ex_d.jal       = 1'b1;
        wb_d.reg_write = 1'b1;
      end
      default: ex_d.illegal = 1'b1;
    endcase
    // an illegal word keeps only its flag
    if (ex_d.illegal) begin
      ex_d         = '0;
      ex_d.illegal = 1'b1;
      mem_d        = '0;
      wb_d         = '0;
    end
  end

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      ex_e  <= '0;
      mem_e <= '0;
      wb_e  <= '0;
      mem_m <= '0;
      wb_m  <= '0;
      wb_w  <= '0;
    end else begin
      if (i_hazard.flush_e) begin
        ex_e  <= '0;
        mem_e <= '0;
        wb_e  <= '0;
      end else begin
        ex_e  <= ex_d;
        mem_e <= mem_d;
        wb_e  <= wb_d;
      end
      // faulting instruction dies before memory
      mem_m <= i_fault ? '0 : mem_e;
      wb_m  <= i_fault ? '0 : wb_e;
      wb_w  <= wb_m;
    end
  end

  assign o_ex_ctrl    = ex_e;
  assign o_mem_ctrl_e = mem_e;
  assign o_mem_ctrl   = mem_m;
  assign o_wb_ctrl    = wb_w;
  assign o_load_e     = mem_e.req & ~mem_e.write;
  assign o_regwrite_m = wb_m.reg_write;
  assign o_regwrite_w = wb_w.reg_write;

endmodule

//--- logic/rv_core.sv
`timescale 1ns/1ns

module rv_core import rv_pkg::*; (
  input  logic        clk,
  input  logic        i_rst_n,
  input  logic [31:0] i_idt,
  input  logic [31:0] i_rdata,
  output logic [31:0] o_iad,
  output dbus_req_t   o_dbus,
  output trap_t       o_trap
);

  // datapath to the others
  logic [31:0] inst_d, pc_e, addr_e;
  logic        taken_e;
  reg_addrs_t  regs;

  // controller outputs
  ex_ctrl_t    ex_ctrl;
  mem_ctrl_t   mem_ctrl, mem_ctrl_e;
  wb_ctrl_t    wb_ctrl;
  logic        load_e, regwrite_m, regwrite_w;

  hazard_t     hazard;
  logic        fault;

  rv_datapath u_datapath (
    .clk        (clk),
    .i_rst_n    (i_rst_n),
    .i_inst     (i_idt),
    .i_rdata    (i_rdata),
    .i_ex_ctrl  (ex_ctrl),
    .i_mem_ctrl (mem_ctrl),
    .i_wb_ctrl  (wb_ctrl),
    .i_hazard   (hazard),
    .i_fault    (fault),
    .o_pc_f     (o_iad),
    .o_inst_d   (inst_d),
    .o_regs     (regs),
    .o_pc_e     (pc_e),
    .o_addr_e   (addr_e),
    .o_taken_e  (taken_e),
    .o_dbus     (o_dbus)
  );

  rv_controller u_controller (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_inst_d     (inst_d),
    .i_hazard     (hazard),
    .i_fault      (fault),
    .o_ex_ctrl    (ex_ctrl),
    .o_mem_ctrl   (mem_ctrl),
    .o_mem_ctrl_e (mem_ctrl_e),
    .o_wb_ctrl    (wb_ctrl),
    .o_load_e     (load_e),
    .o_regwrite_m (regwrite_m),
    .o_regwrite_w (regwrite_w)
  );

  rv_hazard u_hazard (
    .i_regs       (regs),
    .i_load_e     (load_e),
    .i_regwrite_m (regwrite_m),
    .i_regwrite_w (regwrite_w),
    .i_taken_e    (taken_e),
    .i_fault      (fault),
    .o_hazard     (hazard)
  );

  rv_exception u_exception (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_pc_e       (pc_e),
    .i_addr_e     (addr_e),
    .i_ex_ctrl    (ex_ctrl),
    .i_mem_ctrl_e (mem_ctrl_e),
    .o_fault      (fault),
    .o_trap       (o_trap)
  );

endmodule

//--- logic/rv_datapath.sv
`timescale 1ns/1ns
`include "rv_consts.svh"

module rv_datapath import rv_pkg::*; (
  input  logic                clk,
  input  logic                i_rst_n,
  input  logic [`RV_XLEN-1:0] i_inst,
  input  logic [`RV_XLEN-1:0] i_rdata,
  input  ex_ctrl_t            i_ex_ctrl,
  input  mem_ctrl_t           i_mem_ctrl,
  input  wb_ctrl_t            i_wb_ctrl,
  input  hazard_t             i_hazard,
  input  logic                i_fault,
  output logic [`RV_XLEN-1:0] o_pc_f,
  output logic [`RV_XLEN-1:0] o_inst_d,
  output reg_addrs_t          o_regs,
  output logic [`RV_XLEN-1:0] o_pc_e,
  output logic [`RV_XLEN-1:0] o_addr_e,
  output logic                o_taken_e,
  output dbus_req_t           o_dbus
);

  // addi x0, x0, 0
  localparam logic [`RV_XLEN-1:0] NOP = 32'h0000_0013;

  logic [`RV_XLEN-1:0] pc_f, pc_next;
  logic [`RV_XLEN-1:0] inst_d, pc_d, imm_d, rv1_d, rv2_d;
  logic [4:0]          rs1_d, rs2_d, rd_d;
  logic [`RV_XLEN-1:0] regs [`RV_NREGS];

  logic [`RV_XLEN-1:0] pc_e, imm_e, rv1_e, rv2_e;
  logic [4:0]          rs1_e, rs2_e, rd_e;
  logic [`RV_XLEN-1:0] op_a, op_b, alu_b, alu_out, result_e, target_e;
  logic                cond_e, taken_e;

  logic [`RV_XLEN-1:0] result_m, store_m, load_shift, load_m;
  logic [4:0]          rd_m;

  logic [`RV_XLEN-1:0] result_w, load_w, wb_data;
  logic [4:0]          rd_w;

  // fetch: trap beats branch beats stall
  always_comb begin
    if (i_fault) begin
      pc_next = `RV_TRAP_VEC;
    end else if (taken_e) begin
      pc_next = target_e;
    end else if (i_hazard.stall_f) begin
      pc_next = pc_f;
    end else begin
      pc_next = pc_f + 32'd4;
    end
  end

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      pc_f <= `RV_RESET_VEC;
    end else begin
      pc_f <= pc_next;
    end
  end

  // fetch/decode register, a flush inserts a nop
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      inst_d <= NOP;
      pc_d   <= `RV_RESET_VEC;
    end else if (i_hazard.flush_d) begin
      inst_d <= NOP;
    end else if (!i_hazard.stall_d) begin
      inst_d <= i_inst;
      pc_d   <= pc_f;
    end
  end

  assign rs1_d = inst_d[19:15];
  assign rs2_d = inst_d[24:20];
  assign rd_d  = inst_d[11:7];

  // immediate by format
  always_comb begin
    case (opcode_e'(inst_d[6:0]))
      OPC_OP_IMM, OPC_LOAD:
        imm_d = {{20{inst_d[31]}}, inst_d[31:20]};
      OPC_STORE:
        imm_d = {{20{inst_d[31]}}, inst_d[31:25], inst_d[11:7]};
      OPC_BRANCH:
        imm_d = {{19{inst_d[31]}}, inst_d[31], inst_d[7], inst_d[30:25],
                 inst_d[11:8], 1'b0};
      OPC_LUI:
        imm_d = {inst_d[31:12], 12'h000};
      OPC_JAL:
        imm_d = {{11{inst_d[31]}}, inst_d[31], inst_d[19:12], inst_d[20],
                 inst_d[30:21], 1'b0};
      default:
        imm_d = '0;
    endcase
  end

  // register file, writeback visible in the same cycle
  always_ff @(posedge clk) begin
    if (i_wb_ctrl.reg_write && rd_w != 5'd0) begin
      regs[rd_w] <= wb_data;
    end
  end

  always_comb begin
    if (rs1_d == 5'd0) begin
      rv1_d = '0;
    end else if (i_wb_ctrl.reg_write && rd_w == rs1_d) begin
      rv1_d = wb_data;
    end else begin
      rv1_d = regs[rs1_d];
    end
    if (rs2_d == 5'd0) begin
      rv2_d = '0;
    end else if (i_wb_ctrl.reg_write && rd_w == rs2_d) begin
      rv2_d = wb_data;
    end else begin
      rv2_d = regs[rs2_d];
    end
  end

  // decode/execute payload, control is zeroed in the controller
  always_ff @(posedge clk) begin
    pc_e  <= pc_d;
    imm_e <= imm_d;
    rv1_e <= rv1_d;
    rv2_e <= rv2_d;
    rs1_e <= rs1_d;
    rs2_e <= rs2_d;
    rd_e  <= rd_d;
  end

  // operand forwarding
  always_comb begin
    case (i_hazard.fwd_a)
      FWD_FROM_MEM: op_a = result_m;
      FWD_FROM_WB:  op_a = wb_data;
      default:      op_a = rv1_e;
    endcase
    case (i_hazard.fwd_b)
      FWD_FROM_MEM: op_b = result_m;
      FWD_FROM_WB:  op_b = wb_data;
      default:      op_b = rv2_e;
    endcase
  end

  assign alu_b = i_ex_ctrl.alu_src ? imm_e : op_b;

  always_comb begin
    case (i_ex_ctrl.alu_op)
      ALU_SUB:    alu_out = op_a - alu_b;
      ALU_AND:    alu_out = op_a & alu_b;
      ALU_OR:     alu_out = op_a | alu_b;
      ALU_XOR:    alu_out = op_a ^ alu_b;
      ALU_SLT:    alu_out = {31'd0, $signed(op_a) < $signed(alu_b)};
      ALU_SLTU:   alu_out = {31'd0, op_a < alu_b};
      ALU_SLL:    alu_out = op_a << alu_b[4:0];
      ALU_SRL:    alu_out = op_a >> alu_b[4:0];
      ALU_SRA:    alu_out = $signed(op_a) >>> alu_b[4:0];
      ALU_PASS_B: alu_out = alu_b;
      default:    alu_out = op_a + alu_b;
    endcase
  end

  // branch compare on funct3, only beq/bne/blt/bge decode
  always_comb begin
    case (i_ex_ctrl.br_cond)
      3'b000:  cond_e = (op_a == op_b);
      3'b001:  cond_e = (op_a != op_b);
      3'b100:  cond_e = ($signed(op_a) < $signed(op_b));
      3'b101:  cond_e = ($signed(op_a) >= $signed(op_b));
      default: cond_e = 1'b0;
    endcase
  end

  assign taken_e  = i_ex_ctrl.jal | (i_ex_ctrl.branch & cond_e);
  assign target_e = pc_e + imm_e;
  // jal links pc + 4
  assign result_e = i_ex_ctrl.jal ? pc_e + 32'd4 : alu_out;

  always_ff @(posedge clk) begin
    result_m <= result_e;
    store_m  <= op_b;
    rd_m     <= rd_e;
  end

  // memory stage, store data shifted into its byte lanes
  assign o_dbus.req   = i_mem_ctrl.req;
  assign o_dbus.write = i_mem_ctrl.write;
  assign o_dbus.size  = i_mem_ctrl.size;
  assign o_dbus.addr  = result_m;
  assign o_dbus.wdata = store_m << {result_m[1:0], 3'b000};

  assign load_shift = i_rdata >> {result_m[1:0], 3'b000};

  always_comb begin
    case (i_mem_ctrl.size)
      SIZE_BYTE:
        load_m = {{24{i_mem_ctrl.load_signed & load_shift[7]}}, load_shift[7:0]};
      SIZE_HALF:
        load_m = {{16{i_mem_ctrl.load_signed & load_shift[15]}}, load_shift[15:0]};
      default:
        load_m = i_rdata;
    endcase
  end

  always_ff @(posedge clk) begin
    result_w <= result_m;
    load_w   <= load_m;
    rd_w     <= rd_m;
  end

  assign wb_data = i_wb_ctrl.mem_to_reg ? load_w : result_w;

  assign o_pc_f    = pc_f;
  assign o_inst_d  = inst_d;
  assign o_pc_e    = pc_e;
  assign o_addr_e  = alu_out;
  assign o_taken_e = taken_e;

  assign o_regs.rs1_d = rs1_d;
  assign o_regs.rs2_d = rs2_d;
  assign o_regs.rs1_e = rs1_e;
  assign o_regs.rs2_e = rs2_e;
  assign o_regs.rd_e  = rd_e;
  assign o_regs.rd_m  = rd_m;
  assign o_regs.rd_w  = rd_w;

endmodule

//--- logic/rv_exception.sv
`timescale 1ns/1ns

module rv_exception import rv_pkg::*; (
  input  logic        clk,
  input  logic        i_rst_n,
  input  logic [31:0] i_pc_e,
  input  logic [31:0] i_addr_e,
  input  ex_ctrl_t    i_ex_ctrl,
  input  mem_ctrl_t   i_mem_ctrl_e,
  output logic        o_fault,
  output trap_t       o_trap
);

  logic   misaligned;
  cause_e cause;

  assign misaligned = i_mem_ctrl_e.req &&
                      ((i_mem_ctrl_e.size == SIZE_HALF && i_addr_e[0]) ||
                       (i_mem_ctrl_e.size == SIZE_WORD && i_addr_e[1:0] != 2'b00));

  // illegal wins over misaligned
  always_comb begin
    if (i_ex_ctrl.illegal) begin
      cause = CAUSE_ILLEGAL_INST;
    end else if (misaligned) begin
      cause = i_mem_ctrl_e.write ? CAUSE_STORE_MISALIGNED : CAUSE_LOAD_MISALIGNED;
    end else begin
      cause = CAUSE_NONE;
    end
  end

  assign o_fault = i_ex_ctrl.illegal | misaligned;

  // one-cycle report, lines up with the trap vector fetch
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_trap <= '0;
    end else begin
      o_trap.valid <= o_fault;
      o_trap.cause <= cause;
      o_trap.pc    <= i_pc_e;
    end
  end

endmodule

//--- logic/rv_hazard.sv
`timescale 1ns/1ns

module rv_hazard import rv_pkg::*; (
  input  reg_addrs_t i_regs,
  input  logic       i_load_e,
  input  logic       i_regwrite_m,
  input  logic       i_regwrite_w,
  input  logic       i_taken_e,
  input  logic       i_fault,
  output hazard_t    o_hazard
);

  logic load_use, redirect;

  function automatic fwd_sel_e pick_fwd(input logic [4:0] rs, input reg_addrs_t r,
                                        input logic wr_m, input logic wr_w);
    if (rs != 5'd0 && wr_m && r.rd_m == rs) begin
      pick_fwd = FWD_FROM_MEM;
    end else if (rs != 5'd0 && wr_w && r.rd_w == rs) begin
      pick_fwd = FWD_FROM_WB;
    end else begin
      pick_fwd = FWD_REG;
    end
  endfunction

  // load in execute feeding the decode instruction
  assign load_use = i_load_e && i_regs.rd_e != 5'd0 &&
                    (i_regs.rd_e == i_regs.rs1_d || i_regs.rd_e == i_regs.rs2_d);

  assign redirect = i_taken_e | i_fault;

  assign o_hazard.fwd_a   = pick_fwd(i_regs.rs1_e, i_regs, i_regwrite_m, i_regwrite_w);
  assign o_hazard.fwd_b   = pick_fwd(i_regs.rs2_e, i_regs, i_regwrite_m, i_regwrite_w);
  // a redirect discards the stalled instruction anyway
  assign o_hazard.stall_f = load_use & ~redirect;
  assign o_hazard.stall_d = load_use & ~redirect;
  assign o_hazard.flush_d = redirect;
  assign o_hazard.flush_e = redirect | load_use;

endmodule

//--- logic/rv_pkg.sv
`include "rv_consts.svh"

package rv_pkg;

  // major opcodes, inst[6:0]
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT,
    ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_PASS_B
  } alu_op_e;

  // same code as funct3[1:0] of loads and stores
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_WORD = 2'b10
  } mem_size_e;

  typedef enum logic [1:0] {
    FWD_REG, FWD_FROM_MEM, FWD_FROM_WB
  } fwd_sel_e;

  // mcause numbering
  typedef enum logic [3:0] {
    CAUSE_NONE             = 4'd0,
    CAUSE_ILLEGAL_INST     = 4'd2,
    CAUSE_LOAD_MISALIGNED  = 4'd4,
    CAUSE_STORE_MISALIGNED = 4'd6
  } cause_e;

  typedef struct packed {
    alu_op_e    alu_op;
    logic       alu_src;    // 1: immediate as operand b
    logic       branch;
    logic       jal;
    logic [2:0] br_cond;    // funct3 of the branch
    logic       illegal;
  } ex_ctrl_t;

  typedef struct packed {
    logic      req;
    logic      write;
    mem_size_e size;
    logic      load_signed;
  } mem_ctrl_t;

  typedef struct packed {
    logic reg_write;
    logic mem_to_reg;       // 1: load data, 0: alu result
  } wb_ctrl_t;

  typedef struct packed {
    logic [4:0] rs1_d;
    logic [4:0] rs2_d;
    logic [4:0] rs1_e;
    logic [4:0] rs2_e;
    logic [4:0] rd_e;
    logic [4:0] rd_m;
    logic [4:0] rd_w;
  } reg_addrs_t;

  typedef struct packed {
    fwd_sel_e fwd_a;
    fwd_sel_e fwd_b;
    logic     stall_f;
    logic     stall_d;
    logic     flush_d;
    logic     flush_e;
  } hazard_t;

  typedef struct packed {
    logic                req;
    logic                write;
    mem_size_e           size;
    logic [`RV_XLEN-1:0] addr;
    logic [`RV_XLEN-1:0] wdata;
  } dbus_req_t;

  typedef struct packed {
    logic                valid;
    cause_e              cause;
    logic [`RV_XLEN-1:0] pc;
  } trap_t;

endpackage

//--- sim/core_input.txt
# I <addr> <word>   S <stop addr> 0   T <cause> <pc>   M <addr> <expected word>
# all values hex
I 00000000 40000093
I 00000004 12345137
I 00000008 67810113
I 0000000C 002101B3
I 00000010 40218233
I 00000014 FFF24293
I 00000018 4042D313
I 0000001C 0030A023
I 00000020 0050A223
I 00000024 0060A423
I 00000028 0040A383
I 0000002C 00138413
I 00000030 00508483
I 00000034 0050C503
I 00000038 00609583
I 0000003C 0060D603
I 00000040 0080A623
I 00000044 0090A823
I 00000048 00A0AA23
I 0000004C 00B0AC23
I 00000050 00C0AE23
I 00000054 02208023
I 00000058 02209323
I 0000005C 00839663
I 00000060 0220A423
I 00000064 0220A623
I 00000068 00838463
I 0000006C 0220A823
I 00000070 00A4C663
I 00000074 0220AA23
I 00000078 0220AC23
I 0000007C 00A4D463
I 00000080 0220AE23
I 00000084 00C00A6F
I 00000088 0420A023
I 0000008C 0420A223
I 00000090 0540A423
I 00000094 FFFFFFFF
I 00000098 002090A3
I 0000009C 0020A703
# trap handler picks the resume point from the trap count in x20
I 00000100 001A0A13
I 00000104 08900A93
I 00000108 F95A08E3
I 0000010C 001A8A93
I 00000110 F95A06E3
I 00000114 0000006F
S 00000114 0
T 2 00000094
T 6 00000098
T 4 0000009C
M 00000400 2468ACF0
M 00000404 EDCBA987
M 00000408 FEDCBA98
M 0000040C EDCBA988
M 00000410 FFFFFFA9
M 00000414 000000A9
M 00000418 FFFFEDCB
M 0000041C 0000EDCB
M 00000420 00000078
M 00000424 56780000
M 00000428 00000000
M 0000042C 00000000
M 00000430 12345678
M 00000434 00000000
M 00000438 00000000
M 0000043C 12345678
M 00000440 00000000
M 00000444 00000000
M 00000448 00000088

//--- sim/core_sva.sv
`timescale 1ns/1ns
`include "rv_consts.svh"

module core_sva import rv_pkg::*; (
  input logic                clk,
  input logic                i_rst_n,
  input logic [`RV_XLEN-1:0] o_iad,
  input dbus_req_t           o_dbus,
  input trap_t               o_trap
);

  // bus and trap quiet while reset is held
  quiet_in_reset: assert property (@(posedge clk)
    !i_rst_n |-> (!o_dbus.req && !o_dbus.write && !o_trap.valid))
    else $error("bus strobe or trap valid high during reset");

  trap_one_cycle: assert property (@(posedge clk) disable iff (!i_rst_n)
    o_trap.valid |=> !o_trap.valid)
    else $error("trap valid held for two cycles");

  trap_at_vector: assert property (@(posedge clk) disable iff (!i_rst_n)
    o_trap.valid |-> (o_iad == `RV_TRAP_VEC))
    else $error("trap reported while fetch is not at the trap vector");

  write_needs_req: assert property (@(posedge clk) disable iff (!i_rst_n)
    o_dbus.write |-> o_dbus.req)
    else $error("data write without request");

endmodule

//--- sim/tb_clock.sv
`timescale 1ns/1ns

module tb_clock (
  output logic o_clk
);

  // 4 ns period
  initial begin
    o_clk = 1'b0;
  end

  always #2 o_clk = ~o_clk;

endmodule

//--- sim/tb_core.sv
`timescale 1ns/1ns
`include "rv_consts.svh"

module tb_core import rv_pkg::*; ();

  localparam logic [31:0] NOP = 32'h0000_0013;

  logic        clk;
  logic        i_rst_n;
  logic [31:0] i_idt;
  logic [31:0] i_rdata;
  logic [31:0] o_iad;
  dbus_req_t   o_dbus;
  trap_t       o_trap;

  logic [31:0] imem [128];
  logic [31:0] dmem [512];
  logic [31:0] stop_addr;
  logic [31:0] exp_addr [$];
  logic [31:0] exp_word [$];
  logic [3:0]  exp_cause [$];
  logic [31:0] exp_pc [$];
  int          n_words;
  int          trap_idx;
  int          stop_hits;
  int          cycles;
  int          limit;

  tb_clock u_clock (.o_clk(clk));

  rv_core u_rv_core (
    .clk     (clk),
    .i_rst_n (i_rst_n),
    .i_idt   (i_idt),
    .i_rdata (i_rdata),
    .o_iad   (o_iad),
    .o_dbus  (o_dbus),
    .o_trap  (o_trap)
  );

  bind rv_core core_sva u_sva (
    .clk     (clk),
    .i_rst_n (i_rst_n),
    .o_iad   (o_iad),
    .o_dbus  (o_dbus),
    .o_trap  (o_trap)
  );

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic check_word(input string what, input logic [31:0] got,
                            input logic [31:0] exp);
    assert (got === exp) else begin
      stop_with_failure($sformatf("ERR %0t: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic load_input();
    int    fd;
    int    n;
    byte   tag;
    string line;
    logic [31:0] a;
    logic [31:0] b;
    fd = $fopen("sim/core_input.txt", "r");
    if (fd == 0) begin
      stop_with_failure("could not open sim/core_input.txt");
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n > 1 && line[0] != "#") begin
        n = $sscanf(line, "%c %h %h", tag, a, b);
        case (tag)
          "I": begin
            imem[a[8:2]] = b;
            n_words++;
          end
          "S": stop_addr = a;
          "T": begin
            exp_cause.push_back(a[3:0]);
            exp_pc.push_back(b);
          end
          "M": begin
            exp_addr.push_back(a);
            exp_word.push_back(b);
          end
          default: stop_with_failure($sformatf("bad line in input file: %s", line));
        endcase
      end
    end
    $fclose(fd);
  endtask

  // memory models and per-cycle checks on the falling edge
  always @(negedge clk) begin
    if (i_rst_n) begin
      if (o_dbus.req && o_dbus.write) begin
        for (int b = 0; b < 4; b++) begin
          if (o_dbus.size == SIZE_WORD ||
              (o_dbus.size == SIZE_HALF && (b >> 1) == o_dbus.addr[1]) ||
              (o_dbus.size == SIZE_BYTE && b == o_dbus.addr[1:0])) begin
            dmem[o_dbus.addr[10:2]][b*8 +: 8] = o_dbus.wdata[b*8 +: 8];
          end
        end
      end
      if (o_trap.valid) begin
        assert (trap_idx < exp_cause.size()) else begin
          stop_with_failure($sformatf("unexpected trap at pc %h", o_trap.pc));
        end
        check_word("trap cause", 32'(o_trap.cause), 32'(exp_cause[trap_idx]));
        check_word("trap pc", o_trap.pc, exp_pc[trap_idx]);
        trap_idx++;
      end
      if (o_iad == stop_addr) begin
        stop_hits++;
      end
    end
    i_idt   = imem[o_iad[8:2]];
    i_rdata = dmem[o_dbus.addr[10:2]];
  end

  always @(posedge clk) begin
    cycles++;
    if (limit > 0 && cycles > limit) begin
      $display("timeout after %0d cycles, program never reached its stop address", cycles);
      $display("Done: errors found");
      $fatal(1);
    end
  end

  initial begin
    i_rst_n   = 1'b0;
    i_idt     = NOP;
    i_rdata   = '0;
    stop_addr = 32'hffff_ffff;
    n_words   = 0;
    trap_idx  = 0;
    stop_hits = 0;
    cycles    = 0;
    limit     = 0;
    for (int i = 0; i < 128; i++) begin
      imem[i] = NOP;
    end
    for (int i = 0; i < 512; i++) begin
      dmem[i] = '0;
    end
    load_input();
    limit = 20 * n_words + 200;
    repeat (16) @(negedge clk);
    i_rst_n = 1'b1;
    // the final jal loop returns to the stop address every few cycles
    wait (stop_hits >= 8);
    @(negedge clk);
    foreach (exp_addr[i]) begin
      check_word($sformatf("mem[%h]", exp_addr[i]), dmem[exp_addr[i][10:2]], exp_word[i]);
    end
    check_word("trap count", trap_idx, exp_cause.size());
    $display("Done: no errors");
    $finish;
  end

endmodule
